//--- Makefile
VERILATOR := verilator
TOP       := cpuTb
FILELIST  := project.f
FLAGS     := --binary --timing --assert -j 0
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rvSettings.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the log decides the result, not the exit code of the binary
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^PASS: all tests$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- alu.sv
`timescale 1ns/1ps

module alu import rvPkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  aluOpT            op,
    output logic [WIDTH-1:0] result,
    output logic             zero
);

    localparam int SHW = $clog2(WIDTH);

    logic [SHW-1:0] shamt;
    logic           lessSigned;
    logic           lessUnsigned;

    assign shamt        = b[SHW-1:0];
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = {{(WIDTH-1){1'b0}}, lessSigned};
            ALU_SLTU:  result = {{(WIDTH-1){1'b0}}, lessUnsigned};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $signed(a) >>> shamt;
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- controller.sv
`timescale 1ns/1ps

module controller import rvPkg::*; (
    input  logic [31:0] instruction,
    input  logic        aluZero,
    input  logic        aluLsb,
    output aluOpT       aluCtrl,
    output logic        aluImm,
    output logic        aluToPc,
    output logic        branch,
    output loadSelT     loadSel,
    output maskSelT     maskSel,
    output logic        memToReg,
    output logic        memWr,
    output regDataSelT  regDataSel,
    output logic        regWr,
    output logic        rs2ShiftSel,
    output logic        uext,
    output logic        illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       cond;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // alt selects sub and sra
    function automatic aluOpT decodeAluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  decodeAluOp = alt ? ALU_SUB : ALU_ADD;
            3'b001:  decodeAluOp = ALU_SLL;
            3'b010:  decodeAluOp = ALU_SLT;
            3'b011:  decodeAluOp = ALU_SLTU;
            3'b100:  decodeAluOp = ALU_XOR;
            3'b101:  decodeAluOp = alt ? ALU_SRA : ALU_SRL;
            3'b110:  decodeAluOp = ALU_OR;
            default: decodeAluOp = ALU_AND;
        endcase
    endfunction

    // branch compare: equal via subtract, ordering via slt/sltu
    assign cond = funct3[2] ? aluLsb : aluZero;

    always_comb begin
        aluCtrl     = ALU_ADD;
        aluImm      = 1'b0;
        aluToPc     = 1'b0;
        branch      = 1'b0;
        loadSel     = LOAD_WORD;
        maskSel     = MASK_WORD;
        memToReg    = 1'b0;
        memWr       = 1'b0;
        regDataSel  = REG_ALU;
        regWr       = 1'b0;
        rs2ShiftSel = 1'b0;
        uext        = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            OP_LUI: begin
                regDataSel = REG_IMM;
                regWr      = 1'b1;
            end
            OP_AUIPC: begin
                regDataSel = REG_PCIMM;
                regWr      = 1'b1;
            end
            OP_JAL: begin
                branch     = 1'b1;
                regDataSel = REG_PC4;
                regWr      = 1'b1;
            end
            OP_JALR: begin
                aluImm     = 1'b1;
                aluToPc    = 1'b1;
                branch     = 1'b1;
                regDataSel = REG_PC4;
                regWr      = 1'b1;
                illegal    = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                aluCtrl = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
                branch  = cond ^ funct3[0];
                illegal = (funct3[2:1] == 2'b01);
            end
            OP_LOAD: begin
                aluImm   = 1'b1;
                memToReg = 1'b1;
                regWr    = 1'b1;
                uext     = funct3[2];
                loadSel  = (funct3[1:0] == 2'b00) ? LOAD_BYTE :
                           (funct3[1:0] == 2'b01) ? LOAD_HALF : LOAD_WORD;
                illegal  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11) ||
                           (funct3 == 3'b110);
            end
            OP_STORE: begin
                aluImm      = 1'b1;
                memWr       = 1'b1;
                rs2ShiftSel = (funct3 == 3'b001);
                maskSel     = (funct3 == 3'b000) ? MASK_BYTE :
                              (funct3 == 3'b001) ? MASK_HALF : MASK_WORD;
                illegal     = (funct3[2] || funct3[1:0] == 2'b11);
            end
            OP_IMM: begin
                aluImm  = 1'b1;
                regWr   = 1'b1;
                aluCtrl = decodeAluOp(funct3, funct3 == 3'b101 && funct7[5]);
                // shift immediates only allow the srai marker bit
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OP_REG: begin
                regWr   = 1'b1;
                aluCtrl = decodeAluOp(funct3, funct7[5]);
                illegal = !((funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: begin
                // fence, system and anything unknown
                illegal = 1'b1;
            end
        endcase
        if (illegal) begin
            memWr  = 1'b0;
            regWr  = 1'b0;
            branch = 1'b0;
        end
    end

    always_comb begin
        assert #0 (!(memWr && regWr))
            else $error("controller raised memWr and regWr together");
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module cpu import rvPkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      instruction,
    input  logic [`XLEN-1:0] memOut,
    output logic             memWr,
    output logic             except,
    output logic [3:0]       wrMask,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] memAddr,
    output logic [`XLEN-1:0] memIn
);

    aluOpT            aluCtrl;
    loadSelT          loadSel;
    maskSelT          maskSel;
    regDataSelT       regDataSel;
    logic             aluZero, aluImm, aluToPc, branch, memToReg;
    logic             ctrlMemWr, ctrlRegWr, regWr, rs2ShiftSel, uext, illegal;
    logic [1:0]       byteOff;
    logic [4:0]       rs2Shift;
    logic [3:0]       mask;
    logic [7:0]       loadByte;
    logic [15:0]      loadHalf;
    logic [`XLEN-1:0] rs1Data, rs2Data, aluB, aluRes, imm;
    logic [`XLEN-1:0] pc4, pcImm, branchTarget, nextPc;
    logic [`XLEN-1:0] regData, memData, regRes;

    controller ctrl (
        .instruction(instruction), .aluZero(aluZero), .aluLsb(aluRes[0]),
        .aluCtrl(aluCtrl), .aluImm(aluImm), .aluToPc(aluToPc), .branch(branch),
        .loadSel(loadSel), .maskSel(maskSel), .memToReg(memToReg), .memWr(ctrlMemWr),
        .regDataSel(regDataSel), .regWr(ctrlRegWr), .rs2ShiftSel(rs2ShiftSel),
        .uext(uext), .illegal(illegal)
    );

    alu #(.WIDTH(`XLEN)) aluUnit (
        .a(rs1Data), .b(aluB), .op(aluCtrl), .result(aluRes), .zero(aluZero)
    );

    immDecoder immDec (.instruction(instruction), .imm(imm));

    registerFile #(.WIDTH(`XLEN)) regs (
        .clk(clk), .reset(reset), .rs1Addr(instruction[19:15]),
        .rs2Addr(instruction[24:20]), .rdAddr(instruction[11:7]), .rdData(regRes),
        .wrEn(regWr), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // no strobes escape while reset is held
    assign memWr  = ctrlMemWr & ~reset;
    assign regWr  = ctrlRegWr & ~reset;
    assign except = illegal & ~reset;

    assign aluB         = aluImm ? imm : rs2Data;
    assign pc4          = pc + `XLEN'd4;
    assign pcImm        = pc + imm;
    assign branchTarget = aluToPc ? {aluRes[`XLEN-1:1], 1'b0} : pcImm;
    assign nextPc       = branch ? branchTarget : pc4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // halfwords move in pairs of lanes
    assign byteOff  = rs2ShiftSel ? {aluRes[1], 1'b0} : aluRes[1:0];
    assign rs2Shift = {byteOff, 3'b000};
    assign memAddr  = aluRes;
    assign memIn    = rs2Data << rs2Shift;

    always_comb begin
        case (maskSel)
            MASK_BYTE: mask = 4'b0001;
            MASK_HALF: mask = 4'b0011;
            default:   mask = 4'b1111;
        endcase
    end

    assign wrMask = memWr ? (mask << byteOff) : 4'b0000;

    assign loadByte = memOut[{aluRes[1:0], 3'b000} +: 8];
    assign loadHalf = aluRes[1] ? memOut[31:16] : memOut[15:0];

    always_comb begin
        case (loadSel)
            LOAD_BYTE: memData = {{(`XLEN-8){~uext & loadByte[7]}}, loadByte};
            LOAD_HALF: memData = {{(`XLEN-16){~uext & loadHalf[15]}}, loadHalf};
            default:   memData = memOut;
        endcase
    end

    always_comb begin
        case (regDataSel)
            REG_ALU:   regData = aluRes;
            REG_PCIMM: regData = pcImm;
            REG_IMM:   regData = imm;
            default:   regData = pc4;
        endcase
    end

    assign regRes = memToReg ? memData : regData;

    // a store touches one lane, an aligned lane pair or the whole word
    maskLegal: assert property (@(posedge clk) memWr |->
        (wrMask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111}))
        else $error("store raised an illegal byte mask");

endmodule

//--- cpuTb.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module cpuTb;

    localparam int NUM_PROGS  = 4;
    localparam int BODY_LEN   = 120;
    // register setup, data fill, body, register dump, final loop
    localparam int PROG_WORDS = 62 + 8 + BODY_LEN + 31 + 1;
    localparam int TIMEOUT_NS = NUM_PROGS * (2 * PROG_WORDS + 8) * 20 + 1000;

    localparam logic [6:0] LUI    = 7'h37;
    localparam logic [6:0] AUIPC  = 7'h17;
    localparam logic [6:0] JAL    = 7'h6f;
    localparam logic [6:0] JALR   = 7'h67;
    localparam logic [6:0] BRANCH = 7'h63;
    localparam logic [6:0] LOAD   = 7'h03;
    localparam logic [6:0] STORE  = 7'h23;
    localparam logic [6:0] OPIMM  = 7'h13;
    localparam logic [6:0] OPREG  = 7'h33;

    logic        clk = 1'b0;
    logic        reset;
    logic        progWr;
    logic [7:0]  progAddr;
    logic [31:0] progData;
    logic        memWr;
    logic        except;
    logic [3:0]  wrMask;
    logic [31:0] pc;
    logic [31:0] memAddr;
    logic [31:0] memIn;

    logic [31:0] prog [0:255];
    logic [31:0] shReg [0:31];
    logic [31:0] shMem [0:255];
    logic [31:0] shPc;
    logic [31:0] loopPc = 32'd0;
    logic [31:0] lcgState;
    logic        progDone = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          resetCycles = 0;

    socTop UUT (
        .clk(clk), .reset(reset), .progWr(progWr), .progAddr(progAddr),
        .progData(progData), .memWr(memWr), .except(except), .wrMask(wrMask),
        .pc(pc), .memAddr(memAddr), .memIn(memIn)
    );

    always #10 clk = ~clk;

    // two LCG steps, upper halves only
    function automatic logic [31:0] lcgNext();
        logic [31:0] hi;
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        hi = lcgState;
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        lcgNext = {hi[31:16], lcgState[31:16]};
    endfunction

    function automatic logic [31:0] randBelow(input logic [31:0] n);
        randBelow = lcgNext() % n;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        encR = {f7, rs2, rs1, f3, rd, OPREG};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        encI = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [2:0] f3);
        encS = {imm[11:5], rs2, 5'd0, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        encB = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        encJ = {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // one random body instruction; control flow only jumps forward
    function automatic logic [31:0] makeBodyOp(input logic [31:0] pcVal, input logic ctrlOk);
        logic [31:0] kind;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [1:0]  w;
        logic [4:0]  off;
        kind = randBelow(ctrlOk ? 32'd11 : 32'd8);
        r    = lcgNext();
        rd   = 5'(randBelow(32'd32));
        rs1  = 5'(randBelow(32'd32));
        rs2  = 5'(randBelow(32'd32));
        f3   = 3'(randBelow(32'd8));
        imm  = 12'(lcgNext());
        w    = 2'(randBelow(32'd3));
        off  = 5'(randBelow(32'd32));
        if (w == 2'd1) begin
            off[0] = 1'b0;
        end else if (w == 2'd2) begin
            off[1:0] = 2'b00;
        end
        case (kind)
            0, 1: makeBodyOp = encR((f3 == 3'd0 || f3 == 3'd5) && r[0] ? 7'h20 : 7'h00,
                                    rs2, rs1, f3, rd);
            2, 3: begin
                if (f3 == 3'd1) begin
                    imm = {7'h00, rs2};
                end else if (f3 == 3'd5) begin
                    imm = {r[0] ? 7'h20 : 7'h00, rs2};
                end
                makeBodyOp = encI(imm, rs1, f3, rd, OPIMM);
            end
            4: makeBodyOp = {r[31:12], rd, r[0] ? LUI : AUIPC};
            5: makeBodyOp = encI({7'h00, off}, 5'd0, {w == 2'd2 ? 1'b0 : r[4], w}, rd, LOAD);
            6: makeBodyOp = encS({7'h00, off}, rs2, {1'b0, w});
            7: begin
                case (r[2:1])
                    2'd0: makeBodyOp = 32'h0000_0073;
                    2'd1: makeBodyOp = 32'h0000_000f;
                    2'd2: makeBodyOp = encR(7'h01, rs2, rs1, f3, rd);
                    default: makeBodyOp = encI(imm, rs1, 3'b011, rd, LOAD);
                endcase
            end
            8, 9: begin
                f3 = 3'(randBelow(32'd6));
                if (f3 >= 3'd2) begin
                    f3 = f3 + 3'd2;
                end
                // equal operands now and then
                if (r[3:2] == 2'b00) begin
                    rs2 = rs1;
                end
                makeBodyOp = encB(13'd8, rs2, rs1, f3);
            end
            default: begin
                if (r[0]) begin
                    makeBodyOp = encJ(21'd8, rd);
                end else begin
                    makeBodyOp = encI(12'(pcVal + 32'd8 + {31'b0, r[1]}), 5'd0, 3'd0, rd, JALR);
                end
            end
        endcase
    endfunction

    task automatic buildProgram();
        logic [7:0]  n;
        logic [31:0] r;
        n = 8'd0;
        for (int i = 1; i < 32; i++) begin
            r = lcgNext();
            prog[n] = {r[31:12], 5'(i), LUI};
            n = n + 8'd1;
            prog[n] = encI(r[11:0], 5'(i), 3'd0, 5'(i), OPIMM);
            n = n + 8'd1;
        end
        // data words 0 to 7 are the load and store area
        for (int i = 0; i < 8; i++) begin
            prog[n] = encS(12'(i * 4), 5'(randBelow(32'd32)), 3'd2);
            n = n + 8'd1;
        end
        for (int k = 0; k < BODY_LEN; k++) begin
            prog[n] = makeBodyOp({22'b0, n, 2'b00}, k < BODY_LEN - 3);
            n = n + 8'd1;
        end
        for (int i = 1; i < 32; i++) begin
            prog[n] = encS(12'(128 + i * 4), 5'(i), 3'd2);
            n = n + 8'd1;
        end
        loopPc = {22'b0, n, 2'b00};
        prog[n] = encJ(21'd0, 5'd0);
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: aluRef = alt ? a - b : a + b;
            3'd1: aluRef = a << sh;
            3'd2: aluRef = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: aluRef = (a < b) ? 32'd1 : 32'd0;
            3'd4: aluRef = a ^ b;
            3'd5: begin
                if (alt) begin
                    aluRef = $signed(a) >>> sh;
                end else begin
                    aluRef = a >> sh;
                end
            end
            3'd6: aluRef = a | b;
            default: aluRef = a & b;
        endcase
    endfunction

    // reference model, one instruction on the shadow state
    function automatic void refStep(input logic [31:0] ins, output logic expWr,
                                    output logic [31:0] expAddr, output logic [31:0] expData,
                                    output logic [3:0] expMask, output logic expExc);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] bt;
        logic [31:0] hf;
        logic        wb;
        logic        bad;
        logic        take;
        f3   = ins[14:12];
        rd   = ins[11:7];
        a    = shReg[ins[19:15]];
        b    = shReg[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        expWr   = 1'b0;
        expAddr = 32'd0;
        expData = 32'd0;
        expMask = 4'd0;
        res     = 32'd0;
        wb      = 1'b0;
        bad     = 1'b0;
        take    = 1'b0;
        nextPc  = shPc + 32'd4;
        case (ins[6:0])
            LUI: begin
                res = immU;
                wb  = 1'b1;
            end
            AUIPC: begin
                res = shPc + immU;
                wb  = 1'b1;
            end
            JAL: begin
                res    = shPc + 32'd4;
                wb     = 1'b1;
                nextPc = shPc + immJ;
            end
            JALR: begin
                bad    = (f3 != 3'd0);
                res    = shPc + 32'd4;
                wb     = 1'b1;
                nextPc = (a + immI) & ~32'd1;
            end
            BRANCH: begin
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: bad = 1'b1;
                endcase
                if (take) begin
                    nextPc = shPc + immB;
                end
            end
            LOAD: begin
                addr = a + immI;
                word = shMem[addr[9:2]];
                bt   = word >> {addr[1:0], 3'b000};
                hf   = word >> {addr[1], 4'b0000};
                wb   = 1'b1;
                case (f3)
                    3'd0: res = {{24{bt[7]}}, bt[7:0]};
                    3'd1: res = {{16{hf[15]}}, hf[15:0]};
                    3'd2: res = word;
                    3'd4: res = {24'b0, bt[7:0]};
                    3'd5: res = {16'b0, hf[15:0]};
                    default: bad = 1'b1;
                endcase
            end
            STORE: begin
                addr = a + immS;
                case (f3)
                    3'd0: begin
                        expMask = 4'b0001 << addr[1:0];
                        expData = b << {addr[1:0], 3'b000};
                    end
                    3'd1: begin
                        expMask = 4'b0011 << {addr[1], 1'b0};
                        expData = b << {addr[1], 4'b0000};
                    end
                    3'd2: begin
                        expMask = 4'b1111;
                        expData = b;
                    end
                    default: bad = 1'b1;
                endcase
                if (!bad) begin
                    expWr   = 1'b1;
                    expAddr = addr;
                    word    = shMem[addr[9:2]];
                    for (int i = 0; i < 4; i++) begin
                        if (expMask[i]) begin
                            word[i*8 +: 8] = expData[i*8 +: 8];
                        end
                    end
                    shMem[addr[9:2]] = word;
                end
            end
            OPIMM: begin
                if (f3 == 3'd1) begin
                    bad = (ins[31:25] != 7'h00);
                end else if (f3 == 3'd5) begin
                    bad = (ins[31:25] != 7'h00) && (ins[31:25] != 7'h20);
                end
                res = aluRef(f3, f3 == 3'd5 && ins[30], a, immI);
                wb  = 1'b1;
            end
            OPREG: begin
                bad = !(ins[31:25] == 7'h00 ||
                        (ins[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                res = aluRef(f3, ins[30], a, b);
                wb  = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        // an illegal instruction only moves the pc on
        if (bad) begin
            wb      = 1'b0;
            expWr   = 1'b0;
            expMask = 4'd0;
            nextPc  = shPc + 32'd4;
        end
        if (wb && rd != 5'd0) begin
            shReg[rd] = res;
        end
        expExc = bad;
        shPc   = nextPc;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        logic        expWr;
        logic        expExc;
        logic [31:0] expAddr;
        logic [31:0] expData;
        logic [3:0]  expMask;
        if (reset) begin
            // pc only settles after the first reset edge
            if (resetCycles > 0) begin
                checkVal("pc", `RESET_PC, pc);
                checkVal("memWr", 32'd0, 32'(memWr));
                checkVal("except", 32'd0, 32'(except));
            end
            resetCycles++;
            shPc = `RESET_PC;
            for (int i = 0; i < 32; i++) begin
                shReg[i] = 32'd0;
            end
            progDone = 1'b0;
        end else begin
            resetCycles = 0;
            if (shPc == loopPc) begin
                progDone = 1'b1;
            end
            checkVal("pc", shPc, pc);
            refStep(prog[shPc[9:2]], expWr, expAddr, expData, expMask, expExc);
            checkVal("memWr", 32'(expWr), 32'(memWr));
            checkVal("except", 32'(expExc), 32'(except));
            if (expWr) begin
                checkVal("memAddr", expAddr, memAddr);
                checkVal("memIn", expData, memIn);
                checkVal("wrMask", 32'(expMask), 32'(wrMask));
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the programs did not reach their final loop in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        progWr   = 1'b0;
        progAddr = 8'd0;
        progData = 32'd0;
        lcgState = 32'h7e1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            reset = 1'b1;
            buildProgram();
            for (int i = 0; i < PROG_WORDS; i++) begin
                @(negedge clk);
                progWr   = 1'b1;
                progAddr = 8'(i);
                progData = prog[i];
            end
            @(negedge clk);
            progWr = 1'b0;
            repeat (2) @(negedge clk);
            reset = 1'b0;
            while (!progDone) begin
                @(negedge clk);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- immDecoder.sv
`timescale 1ns/1ps

module immDecoder import rvPkg::*; (
    input  logic [31:0] instruction,
    output logic [31:0] imm
);

    logic [6:0] opcode;
    logic       sign;

    assign opcode = instruction[6:0];
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            OP_LOAD, OP_IMM, OP_JALR:
                imm = {{20{sign}}, instruction[31:20]};
            OP_STORE:
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            OP_BRANCH:
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {instruction[31:12], 12'b0};
            OP_JAL:
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            default:
                imm = 32'b0;
        endcase
    end

endmodule

//--- project.f
+incdir+.
rvPkg.sv
alu.sv
immDecoder.sv
registerFile.sv
controller.sv
cpu.sv
socTop.sv
cpuTb.sv

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic [WIDTH-1:0] rdData,
    input  logic             wrEn,
    output logic [WIDTH-1:0] rs1Data,
    output logic [WIDTH-1:0] rs2Data
);

    // entry 0 is cleared by reset and never written
    logic [WIDTH-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    x0Stays: assert property (@(posedge clk) disable iff (reset)
        (wrEn && rdAddr == 5'd0) |=> (regs[0] == '0))
        else $error("write to x0 changed its value");

endmodule

//--- rvPkg.sv
package rvPkg;

    // major opcodes of the retained RV32I subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } aluOpT;

    typedef enum logic [1:0] {
        LOAD_BYTE = 2'd0,
        LOAD_HALF = 2'd1,
        LOAD_WORD = 2'd2
    } loadSelT;

    typedef enum logic [1:0] {
        MASK_BYTE = 2'd0,
        MASK_HALF = 2'd1,
        MASK_WORD = 2'd2
    } maskSelT;

    // write-back source other than memory
    typedef enum logic [1:0] {
        REG_ALU   = 2'd0,
        REG_PCIMM = 2'd1,
        REG_IMM   = 2'd2,
        REG_PC4   = 2'd3
    } regDataSelT;

endpackage

//--- rvSettings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define XLEN 32

// instruction memory depth in words
`define IMEM_WORDS 256

// data memory depth in words
`define DMEM_WORDS 256

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- socTop.sv
`timescale 1ns/1ps
`include "rvSettings.svh"

module socTop (
    input  logic             clk,
    input  logic             reset,
    input  logic             progWr,
    input  logic [7:0]       progAddr,
    input  logic [31:0]      progData,
    output logic             memWr,
    output logic             except,
    output logic [3:0]       wrMask,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] memAddr,
    output logic [`XLEN-1:0] memIn
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [31:0]      imem [0:`IMEM_WORDS-1];
    logic [`XLEN-1:0] dmem [0:`DMEM_WORDS-1];

    logic [31:0]        instruction;
    logic [`XLEN-1:0]   memOut;
    logic [IMEM_AW-1:0] iIdx;
    logic [DMEM_AW-1:0] dIdx;

    cpu core (
        .clk(clk), .reset(reset), .instruction(instruction), .memOut(memOut),
        .memWr(memWr), .except(except), .wrMask(wrMask), .pc(pc),
        .memAddr(memAddr), .memIn(memIn)
    );

    // word addressed, byte offset dropped
    assign iIdx = pc[IMEM_AW+1:2];
    assign dIdx = memAddr[DMEM_AW+1:2];

    // program load port
    always_ff @(posedge clk) begin
        if (progWr) begin
            imem[progAddr[IMEM_AW-1:0]] <= progData;
        end
    end

    assign instruction = imem[iIdx];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (memWr && wrMask[lane]) begin
                dmem[dIdx][lane*8 +: 8] <= memIn[lane*8 +: 8];
            end
        end
    end

    assign memOut = dmem[dIdx];

endmodule
